// ==== hdl/fpa_pkg.sv ====
// fpu mantissa datapath definitions
package fpa_pkg;

	// mantissa is one 40-bit word
	localparam int mant_w = 40;
	// host word and zp bus width
	localparam int word_w = 16;

	// host opcodes
	typedef enum logic [3:0] {
		op_ld_t0  = 4'd0, // T[0:15] from word
		op_ld_t1  = 4'd1, // T[16:31] from word
		op_ld_t2  = 4'd2, // T[32:39] from top byte of word
		op_t_to_c = 4'd3,
		op_t_to_m = 4'd4,
		op_add    = 4'd5,
		op_sub    = 4'd6,
		op_shr    = 4'd7, // T:M pair right
		op_shl    = 4'd8, // T:M pair left
		op_clr    = 4'd9
	} op_e;

	// what the K bus carries into T
	typedef enum logic [1:0] {k_sum, k_m, k_w, k_zero} k_src_e;

	// zp read-out select
	typedef enum logic [1:0] {zp_t_hi, zp_t_mid, zp_t_lo, zp_flags} zp_sel_e;

	// sequencer states, one cycle each
	typedef enum logic [1:0] {
		st_idle,
		st_exec,
		st_resp
	} seq_state_e;

endpackage

// ==== hdl/fpa_t.sv ====
// T accumulator register
`timescale 1ns/100ps
module fpa_t (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            clr_t,
	input  logic [0:2]                      ld_t_seg,
	input  logic                            ld_t_all,
	input  logic                            shr,
	input  logic                            shl,
	// K bus, bit -1 is the extended sign
	input  logic [-1:fpa_pkg::mant_w-1]     k,
	input  logic                            m_0,
	output logic [-1:fpa_pkg::mant_w-1]     t
);
	import fpa_pkg::*;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			t <= '0;
		end else if (clr_t) begin
			t <= '0;
		end else if (ld_t_all) begin
			// full width incl. extension bit from the sum
			t <= k;
		end else if (shr) begin
			// arithmetic, extension bit feeds T[0]
			t <= {t[-1], t[-1:mant_w-2]};
		end else if (shl) begin
			// M[0] enters at the bottom
			t <= {t[0:mant_w-1], m_0};
		end else begin
			// segment loads, seg 0 also sets the extension bit
			if (ld_t_seg[0]) begin
				t[-1:word_w-1] <= k[-1:word_w-1];
			end
			if (ld_t_seg[1]) begin
				t[word_w:2*word_w-1] <= k[word_w:2*word_w-1];
			end
			if (ld_t_seg[2]) begin
				t[2*word_w:mant_w-1] <= k[2*word_w:mant_w-1];
			end
		end
	end

	// only one T action per cycle
	a_one_action: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0({clr_t, |ld_t_seg, ld_t_all, shr, shl}));

endmodule

// ==== hdl/fpa_m.sv ====
// M extension register
`timescale 1ns/100ps
module fpa_m (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        ld_m,
	input  logic                        shr,
	input  logic                        shl,
	input  logic [0:fpa_pkg::mant_w-1]  t,
	output logic [0:fpa_pkg::mant_w-1]  m
);
	import fpa_pkg::*;

	// M is the low half of the 80-bit T:M pair
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			m <= '0;
		end else if (ld_m) begin
			// straight copy of T
			m <= t;
		end else if (shr) begin
			// T[39] drops into M[0]
			m <= {t[mant_w-1], m[0:mant_w-2]};
		end else if (shl) begin
			// M[0] leaves into T[39], zero fills the bottom
			m <= {m[1:mant_w-1], 1'b0};
		end
	end

	// shifts and copy never overlap
	a_m_action: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0({ld_m, shr, shl}));

endmodule

// ==== hdl/fpa_alu.sv ====
// mantissa adder and subtractor
`timescale 1ns/100ps
module fpa_alu (
	input  logic [-1:fpa_pkg::mant_w-1] t,
	input  logic [0:fpa_pkg::mant_w-1]  c,
	input  logic                        sub,
	output logic [-1:fpa_pkg::mant_w-1] sum,
	output logic                        carry,
	output logic [0:1]                  seg_carry
);
	import fpa_pkg::*;

	// second operand, sign extended, inverted for subtract
	logic [-1:mant_w-1] b;
	// carries out of bit 32, bit 16 and bit 0
	logic p32;
	logic p16;
	logic p0;

	assign b = {c[0], c} ^ {(mant_w + 1){sub}};

	// low segment, carry-in 1 completes the two's complement
	assign {p32, sum[2*word_w:mant_w-1]} =
		{1'b0, t[2*word_w:mant_w-1]} + {1'b0, b[2*word_w:mant_w-1]}
		+ {{(mant_w - 2*word_w){1'b0}}, sub};

	// middle segment
	assign {p16, sum[word_w:2*word_w-1]} =
		{1'b0, t[word_w:2*word_w-1]} + {1'b0, b[word_w:2*word_w-1]}
		+ {{word_w{1'b0}}, p32};

	// high segment
	assign {p0, sum[0:word_w-1]} =
		{1'b0, t[0:word_w-1]} + {1'b0, b[0:word_w-1]}
		+ {{word_w{1'b0}}, p16};

	// extension bit gives the true sign on overflow
	assign sum[-1] = t[-1] ^ b[-1] ^ p0;

	assign carry = p0;
	assign seg_carry = {p16, p32};

endmodule

// ==== hdl/fpa.sv ====
// mantissa arithmetic datapath
`timescale 1ns/100ps
module fpa (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic [0:fpa_pkg::word_w-1] w,
	input  fpa_pkg::k_src_e            k_src,
	input  logic [0:2]                 ld_t_seg,
	input  logic                       ld_t_all,
	input  logic                       clr_t,
	input  logic                       shr,
	input  logic                       shl,
	input  logic                       ld_m,
	input  logic                       ld_c,
	input  logic                       sub,
	input  logic                       upd_flags,
	input  fpa_pkg::zp_sel_e           zp_sel,
	output logic [0:fpa_pkg::word_w-1] zp
);
	import fpa_pkg::*;

	logic [-1:mant_w-1] k;
	logic [-1:mant_w-1] t;
	logic [0:mant_w-1]  m;
	logic [0:mant_w-1]  c;
	logic [-1:mant_w-1] sum;
	logic               carry;
	// T as it will be after this edge for the flags
	logic [-1:mant_w-1] t_nx;
	logic               z_f;
	logic               m_f;
	logic               v_f;
	logic               c_f;

	// bit -1 of K carries the sign into T's extension bit
	always_comb begin
		case (k_src)
			k_sum:   k = sum;
			k_m:     k = {m[0], m};
			k_w:     k = {w[0], w, w, w[0:mant_w-2*word_w-1]};
			default: k = '0;
		endcase
	end

	fpa_t u_fpa_t (
		.clk_sys(clk_sys), .rst_n(rst_n), .clr_t(clr_t), .ld_t_seg(ld_t_seg),
		.ld_t_all(ld_t_all), .shr(shr), .shl(shl), .k(k), .m_0(m[0]), .t(t)
	);

	fpa_m u_fpa_m (
		.clk_sys(clk_sys), .rst_n(rst_n), .ld_m(ld_m), .shr(shr), .shl(shl),
		.t(t[0:mant_w-1]), .m(m)
	);

	fpa_alu u_fpa_alu (
		.t(t), .c(c), .sub(sub), .sum(sum), .carry(carry), .seg_carry()
	);

	// C operand register
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			c <= '0;
		end else if (ld_c) begin
			c <= t[0:mant_w-1];
		end
	end

	// flags follow the value T takes at the same edge
	always_comb begin
		if (shr) begin
			t_nx = {t[-1], t[-1:mant_w-2]};
		end else if (shl) begin
			t_nx = {t[0:mant_w-1], m[0]};
		end else begin
			t_nx = sum;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			{z_f, m_f, v_f, c_f} <= 4'b0000;
		end else if (upd_flags) begin
			// zero from the three segment ORs
			z_f <= !(|t_nx[0:word_w-1] || |t_nx[word_w:2*word_w-1]
				|| |t_nx[2*word_w:mant_w-1]);
			m_f <= t_nx[0];
			// sign and extension disagree on overflow
			v_f <= t_nx[0] != t_nx[-1];
			c_f <= carry && !(shr || shl);
		end
	end

	// ZP read-out
	always_comb begin
		case (zp_sel)
			zp_t_hi:  zp = t[0:word_w-1];
			zp_t_mid: zp = t[word_w:2*word_w-1];
			zp_t_lo:  zp = {t[2*word_w:mant_w-1], {(3*word_w-mant_w){1'b0}}};
			default:  zp = {z_f, m_f, v_f, c_f, {(word_w-4){1'b0}}};
		endcase
	end

endmodule

// ==== hdl/fpa_seq.sv ====
// mantissa command sequencer
`timescale 1ns/100ps
module fpa_seq (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              cmd_valid,
	output logic              cmd_ready,
	input  fpa_pkg::op_e      cmd_op,
	input  fpa_pkg::zp_sel_e  cmd_sel,
	output logic              rsp_valid,
	output fpa_pkg::k_src_e   k_src,
	output logic [0:2]        ld_t_seg,
	output logic              ld_t_all,
	output logic              clr_t,
	output logic              shr,
	output logic              shl,
	output logic              ld_m,
	output logic              ld_c,
	output logic              sub,
	output logic              upd_flags,
	output fpa_pkg::zp_sel_e  zp_sel
);
	import fpa_pkg::*;

	seq_state_e state;
	// opcode held for the exec cycle
	op_e        op_q;
	logic       cmd_acc;

	assign cmd_ready = state == st_idle;
	assign rsp_valid = state == st_resp;
	assign cmd_acc = cmd_valid && cmd_ready;

	// idle to exec to resp with one cycle in each
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= st_idle;
			op_q <= op_clr;
			zp_sel <= zp_t_hi;
		end else begin
			case (state)
				st_idle: begin
					if (cmd_acc) begin
						state <= st_exec;
						op_q <= cmd_op;
						// select held until the response
						zp_sel <= cmd_sel;
					end
				end
				st_exec: state <= st_resp;
				default: state <= st_idle;
			endcase
		end
	end

	// strobes only in exec with one action per command
	always_comb begin
		k_src = k_zero;
		ld_t_seg = 3'b000;
		ld_t_all = 1'b0;
		clr_t = 1'b0;
		shr = 1'b0;
		shl = 1'b0;
		ld_m = 1'b0;
		ld_c = 1'b0;
		sub = 1'b0;
		upd_flags = 1'b0;
		if (state == st_exec) begin
			case (op_q)
				op_ld_t0: begin
					k_src = k_w;
					ld_t_seg = 3'b100;
				end
				op_ld_t1: begin
					k_src = k_w;
					ld_t_seg = 3'b010;
				end
				op_ld_t2: begin
					k_src = k_w;
					ld_t_seg = 3'b001;
				end
				op_t_to_c: ld_c = 1'b1;
				op_t_to_m: ld_m = 1'b1;
				op_add, op_sub: begin
					k_src = k_sum;
					ld_t_all = 1'b1;
					sub = op_q == op_sub;
					upd_flags = 1'b1;
				end
				op_shr: begin
					shr = 1'b1;
					upd_flags = 1'b1;
				end
				op_shl: begin
					shl = 1'b1;
					upd_flags = 1'b1;
				end
				op_clr: clr_t = 1'b1;
				// unused codes do nothing but still answer
				default: ;
			endcase
		end
	end

	// accepted command keeps ready and response low through exec, then answers
	a_ready_rsp: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cmd_acc |=> (!cmd_ready && !rsp_valid) ##1 rsp_valid);

	// response is a single-cycle pulse
	a_rsp_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rsp_valid |=> !rsp_valid);

endmodule

// ==== hdl/fpa_top.sv ====
// fpu mantissa unit top level
`timescale 1ns/100ps
module fpa_top (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	// host command port
	input  logic                       cmd_valid,
	output logic                       cmd_ready,
	input  fpa_pkg::op_e               cmd_op,
	input  fpa_pkg::zp_sel_e           cmd_sel,
	input  logic [0:fpa_pkg::word_w-1] cmd_word,
	// response, one pulse per command
	output logic                       rsp_valid,
	output logic [0:fpa_pkg::word_w-1] rsp_data
);
	import fpa_pkg::*;

	// sequencer to datapath strobes
	k_src_e     k_src;
	logic [0:2] ld_t_seg;
	logic       ld_t_all;
	logic       clr_t;
	logic       shr;
	logic       shl;
	logic       ld_m;
	logic       ld_c;
	logic       sub;
	logic       upd_flags;
	zp_sel_e    zp_sel;

	fpa_seq u_fpa_seq (
		.clk_sys(clk_sys), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.cmd_op(cmd_op), .cmd_sel(cmd_sel), .rsp_valid(rsp_valid), .k_src(k_src),
		.ld_t_seg(ld_t_seg), .ld_t_all(ld_t_all), .clr_t(clr_t), .shr(shr), .shl(shl),
		.ld_m(ld_m), .ld_c(ld_c), .sub(sub), .upd_flags(upd_flags), .zp_sel(zp_sel)
	);

	// word goes straight to K, response is the live ZP bus
	fpa u_fpa (
		.clk_sys(clk_sys), .rst_n(rst_n), .w(cmd_word), .k_src(k_src),
		.ld_t_seg(ld_t_seg), .ld_t_all(ld_t_all), .clr_t(clr_t), .shr(shr), .shl(shl),
		.ld_m(ld_m), .ld_c(ld_c), .sub(sub), .upd_flags(upd_flags), .zp_sel(zp_sel),
		.zp(rsp_data)
	);

endmodule

// ==== tb/fpa_clkgen.sv ====
// testbench clock and reset
`timescale 1ns/100ps
module fpa_clkgen (
	output logic clk_sys,
	output logic rst_n
);
	// 8 ns period
	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// reset low over the first two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;
	end
endmodule

// ==== tb/fpa_tb.sv ====
// mantissa unit trace testbench
`timescale 1ns/100ps
module fpa_tb;
	import fpa_pkg::*;

	logic             clk_sys;
	logic             rst_n;
	logic             cmd_valid;
	logic             cmd_ready;
	op_e              cmd_op;
	zp_sel_e          cmd_sel;
	logic [0:15]      cmd_word;
	logic             rsp_valid;
	logic [0:15]      rsp_data;
	// trace columns, one entry per command
	logic [8*24-1:0]  trace_name[$];
	logic [3:0]       trace_op[$];
	logic [1:0]       trace_sel[$];
	logic [15:0]      trace_word[$];
	logic [15:0]      trace_exp[$];
	int               test_count;
	int               test_idx;
	int               cycle_count;
	int               cycle_limit;
	// a command accepted and still waiting for its response
	logic             outstanding;

	fpa_clkgen u_fpa_clkgen (.clk_sys(clk_sys), .rst_n(rst_n));

	fpa_top u_fpa_top (
		.clk_sys(clk_sys), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.cmd_op(cmd_op), .cmd_sel(cmd_sel), .cmd_word(cmd_word),
		.rsp_valid(rsp_valid), .rsp_data(rsp_data)
	);

	// report and stop on the first problem
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	// trace lines: name op sel word expected, hex fields
	task automatic load_trace();
		int               fd;
		int               n;
		logic [8*160-1:0] line_buf;
		logic [8*24-1:0]  name;
		logic [3:0]       op;
		logic [1:0]       sel;
		logic [15:0]      word;
		logic [15:0]      exp_word;
		fd = $fopen("tb/fpa_trace.txt", "r");
		if (fd == 0) begin
			fail_run("could not open the trace file tb/fpa_trace.txt");
		end
		while (!$feof(fd)) begin
			line_buf = '0;
			n = $fgets(line_buf, fd);
			// comment and blank lines never give five fields
			if (n > 0 && $sscanf(line_buf, "%s %h %h %h %h", name, op, sel, word,
					exp_word) == 5) begin
				trace_name.push_back(name);
				trace_op.push_back(op);
				trace_sel.push_back(sel);
				trace_word.push_back(word);
				trace_exp.push_back(exp_word);
			end
		end
		$fclose(fd);
		test_count = trace_name.size();
		if (test_count == 0) begin
			fail_run("the trace file holds no commands");
		end
	endtask

	// one command through handshake and response
	task automatic run_command(input int idx);
		cmd_valid <= 1'b1;
		cmd_op <= op_e'(trace_op[idx]);
		cmd_sel <= zp_sel_e'(trace_sel[idx]);
		// word stays on the bus until the next command, exec reads it
		cmd_word <= trace_word[idx];
		@(posedge clk_sys);
		while (!cmd_ready) begin
			@(posedge clk_sys);
		end
		cmd_valid <= 1'b0;
		outstanding <= 1'b1;
		@(posedge clk_sys);
		while (!rsp_valid) begin
			assert (!cmd_ready) else
				fail_run($sformatf("cmd_ready rose before the response of %0s",
					trace_name[idx]));
			@(posedge clk_sys);
		end
		assert (rsp_data == trace_exp[idx]) else
			fail_run($sformatf("** Error %0s: expected %04h, actual %04h",
				trace_name[idx], trace_exp[idx], rsp_data));
		outstanding <= 1'b0;
	endtask

	// stray response pulse
	always @(posedge clk_sys) begin
		if (rsp_valid) begin
			assert (outstanding) else
				fail_run("a response arrived with no command outstanding");
		end
	end

	// run limit from the trace length
	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			fail_run("timeout, responses stopped arriving");
		end
	end

	initial begin
		cmd_valid = 1'b0;
		cmd_op = op_clr;
		cmd_sel = zp_t_hi;
		cmd_word = '0;
		outstanding = 1'b0;
		load_trace();
		cycle_limit = test_count * 6 + 20;
		// first command after reset is released
		@(posedge clk_sys);
		while (!rst_n) begin
			@(posedge clk_sys);
		end
		for (test_idx = 0; test_idx < test_count; test_idx++) begin
			run_command(test_idx);
		end
		$display("No errors");
		$finish;
	end
endmodule

// ==== tb/fpa_trace.txt ====
# name op sel word expected, all hex; sel 0 hi, 1 mid, 2 lo, 3 flags z m v c
# op 0-2 segment load, 3 T to C, 4 T to M, 5 add, 6 sub, 7 shr, 8 shl, 9 clear
rst_state    3 3 0000 0000
ld_hi        0 0 1234 1234
ld_mid       1 1 5678 5678
ld_lo        2 2 9aff 9a00
copy_c       3 0 0000 1234
ld_mid_ones  1 1 ffff ffff
ld_lo_ones   2 2 ff00 ff00
add_carry    5 1 0000 5678
add_rd_hi    4 0 0000 2469
add_rd_lo    4 2 0000 9900
add_flags    4 3 0000 0000
ld_hi_pos    0 0 7fff 7fff
ovf_copy_c   3 2 0000 9900
add_ovf      5 3 0000 6000
ovf_rd_hi    4 0 0000 fffe
ld_hi_eq     0 0 4000 4000
eq_copy_c    3 1 0000 acf1
sub_eq       6 3 0000 9000
sub_neg      6 0 0000 bfff
neg_copy_m   4 3 0000 4000
shr_sign     7 0 0000 dfff
shr_to_m     7 2 0000 b300
shl_from_m   8 2 0000 6700
clr_t        9 1 0000 0000
clr_rd_hi    4 0 0000 0000

// ==== files.f ====
hdl/fpa_pkg.sv
hdl/fpa_t.sv
hdl/fpa_m.sv
hdl/fpa_alu.sv
hdl/fpa.sv
hdl/fpa_seq.sv
hdl/fpa_top.sv
tb/fpa_clkgen.sv
tb/fpa_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fpa_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TRACE     ?= tb/fpa_trace.txt
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM) $(TRACE)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "No errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
